// ==== src/periph_pkg.sv ====
// Shared types and address map for the peripheral subsystem
// Modules refer to these by scoped name, periph_pkg::name
`default_nettype none

package periph_pkg;

  localparam int NUM_GPIO    = 16;
  localparam int NUM_EXT_IRQ = 4;
  // Source 0 GPIO, 1 timer, 2..5 external lines
  localparam int NUM_IRQ_SRC = 6;

  // GPIO window offsets
  localparam logic [7:0] GPIO_OUT      = 8'h00;
  localparam logic [7:0] GPIO_OE       = 8'h04;
  localparam logic [7:0] GPIO_IN       = 8'h08;
  localparam logic [7:0] GPIO_IRQ_EN   = 8'h0C;
  localparam logic [7:0] GPIO_IRQ_STAT = 8'h10;

  // Timer window offsets
  localparam logic [7:0] TMR_CTRL     = 8'h00;
  localparam logic [7:0] TMR_PRESCALE = 8'h04;
  localparam logic [7:0] TMR_COUNT    = 8'h08;
  localparam logic [7:0] TMR_COMPARE  = 8'h0C;

  // Interrupt controller offsets
  localparam logic [7:0] IRQ_ENABLE  = 8'h00;
  localparam logic [7:0] IRQ_PENDING = 8'h04;
  localparam logic [7:0] IRQ_ID      = 8'h08;

  localparam logic [31:0] ERR_RDATA = 32'hBAD0_0BAD;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } reg_rsp_t;

  // Encoding follows address bits 9:8
  typedef enum logic [1:0] {
    SEL_GPIO  = 2'd0,
    SEL_TIMER = 2'd1,
    SEL_IRQ   = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  // Byte strobes expanded to a bit mask
  function automatic logic [31:0] strb_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

endpackage

`default_nettype wire

// ==== src/bus_to_reg.sv ====
// Bus slave front end with a req/gnt/rvalid handshake
// Registers one request at a time and returns rvalid two cycles after grant
`timescale 1ns/1ns
`default_nettype none

module bus_to_reg (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::bus_req_t bus_req_i,
  output periph_pkg::bus_rsp_t bus_rsp_o,
  output periph_pkg::reg_req_t reg_req_o,
  output logic [31:0]          full_addr_o,
  input  periph_pkg::reg_rsp_t rsp_i
);

  logic        busy_q;
  logic        valid_q;
  logic        rvalid_q;
  logic        accept;
  logic        write_q;
  logic [3:0]  wstrb_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;

  // Grant only while idle
  assign accept = bus_req_i.req & ~busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      valid_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      valid_q  <= accept;
      rvalid_q <= valid_q;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (rvalid_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= bus_req_i.we;
      wstrb_q <= bus_req_i.be;
      addr_q  <= bus_req_i.addr;
      wdata_q <= bus_req_i.wdata;
    end
  end

  always_comb begin
    reg_req_o.valid = valid_q;
    reg_req_o.write = write_q;
    reg_req_o.wstrb = wstrb_q;
    reg_req_o.addr  = addr_q[7:0];
    reg_req_o.wdata = wdata_q;
  end

  // Full address lets the decoder spot unmapped windows
  assign full_addr_o = addr_q;

  always_comb begin
    bus_rsp_o.gnt    = ~busy_q;
    bus_rsp_o.rvalid = rvalid_q;
    bus_rsp_o.err    = rvalid_q & rsp_i.err;
    bus_rsp_o.rdata  = rsp_i.rdata;
  end

endmodule

`default_nettype wire

// ==== src/periph_decode.sv ====
// Address decoder and response mux for the three peripheral windows
// Valid goes only to the selected peripheral, its response is registered
`timescale 1ns/1ns
`default_nettype none

module periph_decode (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  input  logic [31:0]          full_addr_i,
  output periph_pkg::reg_req_t gpio_req_o,
  output periph_pkg::reg_req_t timer_req_o,
  output periph_pkg::reg_req_t irq_req_o,
  input  periph_pkg::reg_rsp_t gpio_rsp_i,
  input  periph_pkg::reg_rsp_t timer_rsp_i,
  input  periph_pkg::reg_rsp_t irq_rsp_i,
  output periph_pkg::reg_rsp_t rsp_o
);

  periph_pkg::periph_sel_e sel;
  periph_pkg::reg_rsp_t    sel_rsp;
  periph_pkg::reg_rsp_t    rsp_q;

  always_comb begin
    if (|full_addr_i[31:10]) begin
      sel = periph_pkg::SEL_NONE;
    end else begin
      case (full_addr_i[9:8])
        2'd0:    sel = periph_pkg::SEL_GPIO;
        2'd1:    sel = periph_pkg::SEL_TIMER;
        2'd2:    sel = periph_pkg::SEL_IRQ;
        default: sel = periph_pkg::SEL_NONE;
      endcase
    end
  end

  // Same request to all, valid gated per window
  always_comb begin
    gpio_req_o        = reg_req_i;
    timer_req_o       = reg_req_i;
    irq_req_o         = reg_req_i;
    gpio_req_o.valid  = reg_req_i.valid & (sel == periph_pkg::SEL_GPIO);
    timer_req_o.valid = reg_req_i.valid & (sel == periph_pkg::SEL_TIMER);
    irq_req_o.valid   = reg_req_i.valid & (sel == periph_pkg::SEL_IRQ);
  end

  always_comb begin
    case (sel)
      periph_pkg::SEL_GPIO:  sel_rsp = gpio_rsp_i;
      periph_pkg::SEL_TIMER: sel_rsp = timer_rsp_i;
      periph_pkg::SEL_IRQ:   sel_rsp = irq_rsp_i;
      default: begin
        sel_rsp.rdata = periph_pkg::ERR_RDATA;
        sel_rsp.err   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_q <= '0;
    end else if (reg_req_i.valid) begin
      rsp_q <= sel_rsp;
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== src/gpio_regs.sv ====
// GPIO register block with output, output enable and rising-edge interrupts
// Inputs pass a two-flop synchronizer before edge detection
`timescale 1ns/1ns
`default_nettype none

module gpio_regs (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  periph_pkg::reg_req_t            req_i,
  output periph_pkg::reg_rsp_t            rsp_o,
  input  logic [periph_pkg::NUM_GPIO-1:0] gpio_i,
  output logic [periph_pkg::NUM_GPIO-1:0] gpio_o,
  output logic [periph_pkg::NUM_GPIO-1:0] gpio_en_o,
  output logic                            irq_o
);

  logic [periph_pkg::NUM_GPIO-1:0] out_q;
  logic [periph_pkg::NUM_GPIO-1:0] oe_q;
  logic [periph_pkg::NUM_GPIO-1:0] irq_en_q;
  logic [periph_pkg::NUM_GPIO-1:0] stat_q;
  logic [periph_pkg::NUM_GPIO-1:0] in_meta_q;
  logic [periph_pkg::NUM_GPIO-1:0] in_sync_q;
  logic [periph_pkg::NUM_GPIO-1:0] in_prev_q;
  logic [periph_pkg::NUM_GPIO-1:0] rise;
  logic [periph_pkg::NUM_GPIO-1:0] wmask;
  logic [periph_pkg::NUM_GPIO-1:0] wdata;
  logic [31:0]                     full_mask;
  logic                            wr;

  assign full_mask = periph_pkg::strb_mask(req_i.wstrb);
  assign wmask     = full_mask[periph_pkg::NUM_GPIO-1:0];
  assign wdata     = req_i.wdata[periph_pkg::NUM_GPIO-1:0];
  assign wr        = req_i.valid & req_i.write;
  assign rise      = in_sync_q & ~in_prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      irq_en_q <= '0;
      stat_q   <= '0;
    end else begin
      if (wr && req_i.addr == periph_pkg::GPIO_OUT) begin
        out_q <= (out_q & ~wmask) | (wdata & wmask);
      end
      if (wr && req_i.addr == periph_pkg::GPIO_OE) begin
        oe_q <= (oe_q & ~wmask) | (wdata & wmask);
      end
      if (wr && req_i.addr == periph_pkg::GPIO_IRQ_EN) begin
        irq_en_q <= (irq_en_q & ~wmask) | (wdata & wmask);
      end
      // New edges win over a clear in the same cycle
      if (wr && req_i.addr == periph_pkg::GPIO_IRQ_STAT) begin
        stat_q <= (stat_q & ~(wdata & wmask)) | (rise & irq_en_q);
      end else begin
        stat_q <= stat_q | (rise & irq_en_q);
      end
    end
  end

  always_comb begin
    rsp_o.err   = 1'b0;
    rsp_o.rdata = '0;
    case (req_i.addr)
      periph_pkg::GPIO_OUT:      rsp_o.rdata[periph_pkg::NUM_GPIO-1:0] = out_q;
      periph_pkg::GPIO_OE:       rsp_o.rdata[periph_pkg::NUM_GPIO-1:0] = oe_q;
      periph_pkg::GPIO_IN:       rsp_o.rdata[periph_pkg::NUM_GPIO-1:0] = in_sync_q;
      periph_pkg::GPIO_IRQ_EN:   rsp_o.rdata[periph_pkg::NUM_GPIO-1:0] = irq_en_q;
      periph_pkg::GPIO_IRQ_STAT: rsp_o.rdata[periph_pkg::NUM_GPIO-1:0] = stat_q;
      default: begin
        rsp_o.rdata = periph_pkg::ERR_RDATA;
        rsp_o.err   = 1'b1;
      end
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign irq_o     = |stat_q;

endmodule

`default_nettype wire

// ==== src/timer_regs.sv ====
// 32-bit timer with prescaler and a level compare interrupt
// Count steps once every PRESCALE+1 clocks while CTRL bit 0 is set
`timescale 1ns/1ns
`default_nettype none

module timer_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t req_i,
  output periph_pkg::reg_rsp_t rsp_o,
  output logic                 irq_o
);

  logic        en_q;
  logic [31:0] prescale_q;
  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic [31:0] presc_cnt_q;
  logic [31:0] wmask;
  logic        wr;
  logic        tick;

  assign wmask = periph_pkg::strb_mask(req_i.wstrb);
  assign wr    = req_i.valid & req_i.write;
  assign tick  = en_q & (presc_cnt_q == prescale_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q        <= 1'b0;
      prescale_q  <= '0;
      count_q     <= '0;
      compare_q   <= '0;
      presc_cnt_q <= '0;
    end else begin
      if (wr && req_i.addr == periph_pkg::TMR_CTRL && wmask[0]) begin
        en_q <= req_i.wdata[0];
      end
      if (wr && req_i.addr == periph_pkg::TMR_PRESCALE) begin
        prescale_q <= (prescale_q & ~wmask) | (req_i.wdata & wmask);
      end
      if (wr && req_i.addr == periph_pkg::TMR_COMPARE) begin
        compare_q <= (compare_q & ~wmask) | (req_i.wdata & wmask);
      end
      // Count load restarts the prescaler
      if (wr && req_i.addr == periph_pkg::TMR_COUNT) begin
        count_q     <= (count_q & ~wmask) | (req_i.wdata & wmask);
        presc_cnt_q <= '0;
      end else if (!en_q) begin
        presc_cnt_q <= '0;
      end else if (tick) begin
        count_q     <= count_q + 32'd1;
        presc_cnt_q <= '0;
      end else begin
        presc_cnt_q <= presc_cnt_q + 32'd1;
      end
    end
  end

  always_comb begin
    rsp_o.err = 1'b0;
    case (req_i.addr)
      periph_pkg::TMR_CTRL:     rsp_o.rdata = {31'd0, en_q};
      periph_pkg::TMR_PRESCALE: rsp_o.rdata = prescale_q;
      periph_pkg::TMR_COUNT:    rsp_o.rdata = count_q;
      periph_pkg::TMR_COMPARE:  rsp_o.rdata = compare_q;
      default: begin
        rsp_o.rdata = periph_pkg::ERR_RDATA;
        rsp_o.err   = 1'b1;
      end
    endcase
  end

  assign irq_o = en_q & (count_q >= compare_q);

endmodule

`default_nettype wire

// ==== src/irq_ctrl.sv ====
// Interrupt controller with per-source enable, lowest source number wins
// irq_id_o is the winning source plus one, zero when nothing is pending
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  periph_pkg::reg_req_t               req_i,
  output periph_pkg::reg_rsp_t               rsp_o,
  input  logic                               gpio_irq_i,
  input  logic                               timer_irq_i,
  input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                               irq_o,
  output logic [2:0]                         irq_id_o
);

  logic [periph_pkg::NUM_IRQ_SRC-1:0] enable_q;
  logic [periph_pkg::NUM_IRQ_SRC-1:0] src;
  logic [periph_pkg::NUM_IRQ_SRC-1:0] pending;
  logic [31:0]                        wmask;
  logic [2:0]                         id;

  assign wmask   = periph_pkg::strb_mask(req_i.wstrb);
  assign src     = {ext_irq_i, timer_irq_i, gpio_irq_i};
  assign pending = src & enable_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q <= '0;
    end else if (req_i.valid && req_i.write && req_i.addr == periph_pkg::IRQ_ENABLE) begin
      enable_q <= (enable_q & ~wmask[periph_pkg::NUM_IRQ_SRC-1:0])
                | (req_i.wdata[periph_pkg::NUM_IRQ_SRC-1:0]
                   & wmask[periph_pkg::NUM_IRQ_SRC-1:0]);
    end
  end

  // Scan from the top so the lowest pending source is left
  always_comb begin
    id = 3'd0;
    for (int i = periph_pkg::NUM_IRQ_SRC - 1; i >= 0; i--) begin
      if (pending[i]) begin
        id = 3'(i + 1);
      end
    end
  end

  assign irq_o    = |pending;
  assign irq_id_o = id;

  always_comb begin
    rsp_o.err   = 1'b0;
    rsp_o.rdata = '0;
    case (req_i.addr)
      periph_pkg::IRQ_ENABLE:  rsp_o.rdata[periph_pkg::NUM_IRQ_SRC-1:0] = enable_q;
      periph_pkg::IRQ_PENDING: rsp_o.rdata[periph_pkg::NUM_IRQ_SRC-1:0] = pending;
      periph_pkg::IRQ_ID:      rsp_o.rdata[2:0] = id;
      default: begin
        rsp_o.rdata = periph_pkg::ERR_RDATA;
        rsp_o.err   = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/periph_subsystem.sv ====
// Peripheral subsystem top with GPIO, timer and interrupt controller
// Core bus in, pins and the combined interrupt out
`timescale 1ns/1ns
`default_nettype none

module periph_subsystem (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  periph_pkg::bus_req_t               bus_req_i,
  output periph_pkg::bus_rsp_t               bus_rsp_o,
  input  logic [periph_pkg::NUM_GPIO-1:0]    gpio_i,
  output logic [periph_pkg::NUM_GPIO-1:0]    gpio_o,
  output logic [periph_pkg::NUM_GPIO-1:0]    gpio_en_o,
  input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                               irq_o,
  output logic [2:0]                         irq_id_o
);

  periph_pkg::reg_req_t reg_req;
  periph_pkg::reg_rsp_t reg_rsp;
  logic [31:0]          full_addr;

  periph_pkg::reg_req_t gpio_req;
  periph_pkg::reg_rsp_t gpio_rsp;
  periph_pkg::reg_req_t timer_req;
  periph_pkg::reg_rsp_t timer_rsp;
  periph_pkg::reg_req_t irq_req;
  periph_pkg::reg_rsp_t irq_rsp;

  logic gpio_irq;
  logic timer_irq;

  bus_to_reg u_bus_to_reg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (bus_req_i),
    .bus_rsp_o   (bus_rsp_o),
    .reg_req_o   (reg_req),
    .full_addr_o (full_addr),
    .rsp_i       (reg_rsp)
  );

  periph_decode u_periph_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (reg_req),
    .full_addr_i (full_addr),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .irq_req_o   (irq_req),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp),
    .irq_rsp_i   (irq_rsp),
    .rsp_o       (reg_rsp)
  );

  gpio_regs u_gpio_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .irq_o     (gpio_irq)
  );

  timer_regs u_timer_regs (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (timer_req),
    .rsp_o   (timer_rsp),
    .irq_o   (timer_irq)
  );

  irq_ctrl u_irq_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (irq_req),
    .rsp_o       (irq_rsp),
    .gpio_irq_i  (gpio_irq),
    .timer_irq_i (timer_irq),
    .ext_irq_i   (ext_irq_i),
    .irq_o       (irq_o),
    .irq_id_o    (irq_id_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_periph_subsystem.sv ====
// Directed testbench for the peripheral subsystem
// Drives the core bus, GPIO pins and external interrupt lines and checks the responses
`timescale 1ns/1ns
`default_nettype none

module tb_periph_subsystem;

  // Tests need a few hundred cycles and the timer wait is the longest part
  localparam int MAX_CYCLES = 4000;

  logic                               clk;
  logic                               rst_n;
  periph_pkg::bus_req_t               bus_req;
  periph_pkg::bus_rsp_t               bus_rsp;
  logic [periph_pkg::NUM_GPIO-1:0]    gpio_in;
  logic [periph_pkg::NUM_GPIO-1:0]    gpio_out;
  logic [periph_pkg::NUM_GPIO-1:0]    gpio_en;
  logic [periph_pkg::NUM_EXT_IRQ-1:0] ext_irq;
  logic                               irq;
  logic [2:0]                         irq_id;

  int errors;
  int cycles;
  int seed;

  periph_subsystem DUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_en_o (gpio_en),
    .ext_irq_i (ext_irq),
    .irq_o     (irq),
    .irq_id_o  (irq_id)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Inputs change and outputs are sampled 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // Window 0 GPIO, 1 timer, 2 interrupt controller
  function automatic logic [31:0] reg_addr(input logic [1:0] win, input logic [7:0] off);
    return {22'd0, win, off};
  endfunction

  function automatic logic [2:0] lowest_id(input logic [5:0] pend);
    logic [2:0] id;
    id = 3'd0;
    for (int i = 0; i < 6; i++) begin
      if (pend[i] && id == 3'd0) begin
        id = 3'(i + 1);
      end
    end
    return id;
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_gpio(input string what, input logic [periph_pkg::NUM_GPIO-1:0] got,
                            input logic [periph_pkg::NUM_GPIO-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_irq(input logic got_irq, input logic [2:0] got_id,
                           input logic exp_irq, input logic [2:0] exp_id);
    if (got_irq !== exp_irq || got_id !== exp_id) begin
      errors++;
      $display("ERR %0t: irq/id got %b/%0d expected %b/%0d", $time,
               got_irq, got_id, exp_irq, exp_id);
    end
  endtask

  task automatic check_range(input string what, input logic [31:0] got,
                             input logic [31:0] lo, input logic [31:0] hi);
    if (got < lo || got > hi) begin
      errors++;
      $display("ERR %0t: %s got %0d expected %0d..%0d", $time, what, got, lo, hi);
    end
  endtask

  // One transfer whose rvalid must come exactly two cycles after the grant
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.be    = be;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    while (!bus_rsp.gnt) begin
      next_cycle();
    end
    next_cycle();
    bus_req.req = 1'b0;
    check_flag("gnt at T+1", bus_rsp.gnt, 1'b0);
    check_flag("rvalid at T+1", bus_rsp.rvalid, 1'b0);
    next_cycle();
    check_flag("gnt at T+2", bus_rsp.gnt, 1'b0);
    check_flag("rvalid at T+2", bus_rsp.rvalid, 1'b1);
    rdata = bus_rsp.rdata;
    err   = bus_rsp.err;
    next_cycle();
    check_flag("gnt at T+3", bus_rsp.gnt, 1'b1);
    check_flag("rvalid at T+3", bus_rsp.rvalid, 1'b0);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b1, be, addr, wdata, rd, err);
    check_flag("write err", err, 1'b0);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic err;
    bus_access(1'b0, 4'hF, addr, 32'd0, rdata, err);
    check_flag("read err", err, 1'b0);
  endtask

  task automatic test_reset_state();
    check_flag("gnt after reset", bus_rsp.gnt, 1'b1);
    check_flag("rvalid after reset", bus_rsp.rvalid, 1'b0);
    check_gpio("gpio_o after reset", gpio_out, '0);
    check_gpio("gpio_en_o after reset", gpio_en, '0);
    check_irq(irq, irq_id, 1'b0, 3'd0);
  endtask

  task automatic test_gpio_outputs();
    logic [31:0] val;
    logic [31:0] oe;
    logic [31:0] nv;
    logic [31:0] rd;
    val = rand_word();
    oe  = rand_word();
    nv  = rand_word();
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_OUT), 4'hF, val);
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_OE), 4'hF, oe);
    check_gpio("gpio_o", gpio_out, val[15:0]);
    check_gpio("gpio_en_o", gpio_en, oe[15:0]);
    bus_read(reg_addr(2'd0, periph_pkg::GPIO_OUT), rd);
    check_word("GPIO_OUT readback", rd, {16'd0, val[15:0]});
    bus_read(reg_addr(2'd0, periph_pkg::GPIO_OE), rd);
    check_word("GPIO_OE readback", rd, {16'd0, oe[15:0]});
    // Only byte 1 may change
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_OUT), 4'b0010, nv);
    check_gpio("gpio_o byte write", gpio_out, {nv[15:8], val[7:0]});
  endtask

  task automatic test_gpio_inputs();
    logic [31:0] v;
    logic [31:0] rd;
    v = rand_word();
    gpio_in = v[15:0];
    repeat (3) next_cycle();
    bus_read(reg_addr(2'd0, periph_pkg::GPIO_IN), rd);
    check_word("GPIO_IN", rd, {16'd0, v[15:0]});
    gpio_in = '0;
    repeat (3) next_cycle();
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_IRQ_EN), 4'hF, 32'h0000_00F0);
    // Pin 8 rises too but is not enabled
    gpio_in = 16'h0130;
    repeat (4) next_cycle();
    check_irq(irq, irq_id, 1'b0, 3'd0);
    bus_write(reg_addr(2'd2, periph_pkg::IRQ_ENABLE), 4'hF, 32'h0000_0001);
    check_irq(irq, irq_id, 1'b1, 3'd1);
    bus_read(reg_addr(2'd0, periph_pkg::GPIO_IRQ_STAT), rd);
    check_word("GPIO_IRQ_STAT", rd, 32'h0000_0030);
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_IRQ_STAT), 4'hF, 32'h0000_0010);
    bus_read(reg_addr(2'd0, periph_pkg::GPIO_IRQ_STAT), rd);
    check_word("GPIO_IRQ_STAT partial clear", rd, 32'h0000_0020);
    check_irq(irq, irq_id, 1'b1, 3'd1);
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_IRQ_STAT), 4'hF, 32'h0000_0020);
    check_irq(irq, irq_id, 1'b0, 3'd0);
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_IRQ_EN), 4'hF, 32'd0);
    bus_write(reg_addr(2'd2, periph_pkg::IRQ_ENABLE), 4'hF, 32'd0);
    gpio_in = '0;
  endtask

  // Count reaches COMPARE after COMPARE*(PRESCALE+1) = 80 clocks
  task automatic test_timer();
    logic [31:0] rd;
    bus_write(reg_addr(2'd2, periph_pkg::IRQ_ENABLE), 4'hF, 32'h0000_0002);
    bus_write(reg_addr(2'd1, periph_pkg::TMR_PRESCALE), 4'hF, 32'd3);
    bus_write(reg_addr(2'd1, periph_pkg::TMR_COMPARE), 4'hF, 32'd20);
    bus_write(reg_addr(2'd1, periph_pkg::TMR_COUNT), 4'hF, 32'd0);
    bus_write(reg_addr(2'd1, periph_pkg::TMR_CTRL), 4'hF, 32'd1);
    repeat (70) begin
      check_irq(irq, irq_id, 1'b0, 3'd0);
      next_cycle();
    end
    bus_read(reg_addr(2'd1, periph_pkg::TMR_COUNT), rd);
    check_range("TMR_COUNT", rd, 32'd16, 32'd19);
    repeat (12) next_cycle();
    check_irq(irq, irq_id, 1'b1, 3'd2);
    bus_write(reg_addr(2'd1, periph_pkg::TMR_COUNT), 4'hF, 32'd0);
    check_irq(irq, irq_id, 1'b0, 3'd0);
    bus_write(reg_addr(2'd1, periph_pkg::TMR_CTRL), 4'hF, 32'd0);
    bus_write(reg_addr(2'd2, periph_pkg::IRQ_ENABLE), 4'hF, 32'd0);
  endtask

  task automatic test_irq_ctrl();
    logic [31:0] rnd;
    logic [5:0]  en;
    logic [5:0]  exp_pend;
    logic [31:0] rd;
    for (int i = 0; i < 8; i++) begin
      rnd = rand_word();
      en  = rnd[5:0];
      bus_write(reg_addr(2'd2, periph_pkg::IRQ_ENABLE), 4'hF, {26'd0, en});
      ext_irq = rnd[11:8];
      next_cycle();
      exp_pend = {rnd[11:8], 2'b00} & en;
      check_irq(irq, irq_id, |exp_pend, lowest_id(exp_pend));
      bus_read(reg_addr(2'd2, periph_pkg::IRQ_PENDING), rd);
      check_word("IRQ_PENDING", rd, {26'd0, exp_pend});
      bus_read(reg_addr(2'd2, periph_pkg::IRQ_ID), rd);
      check_word("IRQ_ID", rd, {29'd0, lowest_id(exp_pend)});
    end
    bus_write(reg_addr(2'd2, periph_pkg::IRQ_PENDING), 4'hF, 32'h0000_003F);
    bus_read(reg_addr(2'd2, periph_pkg::IRQ_PENDING), rd);
    check_word("IRQ_PENDING after write", rd, {26'd0, exp_pend});
    ext_irq = '0;
    bus_write(reg_addr(2'd2, periph_pkg::IRQ_ENABLE), 4'hF, 32'd0);
  endtask

  task automatic test_errors();
    logic [31:0] rd;
    logic        err;
    bus_write(reg_addr(2'd0, periph_pkg::GPIO_OUT), 4'hF, 32'h0000_1234);
    bus_access(1'b1, 4'hF, 32'h0000_0300, 32'hFFFF_FFFF, rd, err);
    check_flag("window 3 write err", err, 1'b1);
    bus_access(1'b0, 4'hF, 32'h0000_0300, 32'd0, rd, err);
    check_flag("window 3 read err", err, 1'b1);
    check_word("window 3 read data", rd, periph_pkg::ERR_RDATA);
    // High bits set while the low bits alias GPIO_OUT
    bus_access(1'b1, 4'hF, 32'h0000_1000, 32'h0000_FFFF, rd, err);
    check_flag("high address write err", err, 1'b1);
    bus_access(1'b0, 4'hF, 32'h8000_0000, 32'd0, rd, err);
    check_flag("high address read err", err, 1'b1);
    check_word("high address read data", rd, periph_pkg::ERR_RDATA);
    bus_access(1'b0, 4'hF, reg_addr(2'd0, 8'h14), 32'd0, rd, err);
    check_flag("GPIO unknown offset err", err, 1'b1);
    check_word("GPIO unknown offset data", rd, periph_pkg::ERR_RDATA);
    bus_access(1'b1, 4'hF, reg_addr(2'd1, 8'h10), 32'd0, rd, err);
    check_flag("timer unknown offset err", err, 1'b1);
    bus_read(reg_addr(2'd0, periph_pkg::GPIO_OUT), rd);
    check_word("GPIO_OUT after bad writes", rd, 32'h0000_1234);
    check_gpio("gpio_o after bad writes", gpio_out, 16'h1234);
    bus_read(reg_addr(2'd1, periph_pkg::TMR_COMPARE), rd);
    check_word("TMR_COMPARE after bad writes", rd, 32'd20);
  endtask

  // req stays high and each transfer is accepted as soon as gnt returns
  task automatic test_bus_timing();
    logic [31:0] exp_data;
    bus_req.req = 1'b1;
    bus_req.be  = 4'hF;
    for (int k = 0; k < 4; k++) begin
      exp_data      = (k < 2) ? 32'h0000_A5A5 : 32'h0000_5A5A;
      bus_req.we    = (k % 2 == 0);
      bus_req.addr  = reg_addr(2'd0, periph_pkg::GPIO_OUT);
      bus_req.wdata = exp_data;
      check_flag("gnt with req held", bus_rsp.gnt, 1'b1);
      check_flag("rvalid before acceptance", bus_rsp.rvalid, 1'b0);
      next_cycle();
      if (k == 3) begin
        bus_req.req = 1'b0;
      end
      check_flag("held gnt at T+1", bus_rsp.gnt, 1'b0);
      check_flag("held rvalid at T+1", bus_rsp.rvalid, 1'b0);
      next_cycle();
      check_flag("held gnt at T+2", bus_rsp.gnt, 1'b0);
      check_flag("held rvalid at T+2", bus_rsp.rvalid, 1'b1);
      check_flag("held err", bus_rsp.err, 1'b0);
      if (!bus_req.we) begin
        check_word("back-to-back readback", bus_rsp.rdata, exp_data);
      end
      next_cycle();
    end
    check_flag("rvalid after last transfer", bus_rsp.rvalid, 1'b0);
    check_flag("gnt after last transfer", bus_rsp.gnt, 1'b1);
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    bus_req = '0;
    gpio_in = '0;
    ext_irq = '0;
    errors  = 0;
    cycles  = 0;
    seed    = 32'hd2b2d89c;
    repeat (3) next_cycle();
    rst_n = 1'b1;
    next_cycle();
    test_reset_state();
    test_gpio_outputs();
    test_gpio_inputs();
    test_timer();
    test_irq_ctrl();
    test_errors();
    test_bus_timing();
    $display("Errors: %0d in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/periph_pkg.sv
src/bus_to_reg.sv
src/periph_decode.sv
src/gpio_regs.sv
src/timer_regs.sv
src/irq_ctrl.sv
src/periph_subsystem.sv
test/tb_periph_subsystem.sv
